// ==== bench/router_switch_chk.sv ====
`timescale 1ns/100ps

module router_switch_chk (
        input logic                  clk,
        input logic                  arst_n_i,
        input noc_pkg::flit_array_t  in_flit_i,
        input noc_pkg::grant_array_t grant_i,
        input noc_pkg::flit_array_t  out_flit_i
);

        for (genvar o = 0; o < noc_pkg::NUM_PORTS; o++) begin : g_out
                a_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
                        $onehot0(grant_i[o]))
                        else $error("output %0d granted more than one input", o);

                a_no_uturn: assert property (@(posedge clk) disable iff (!arst_n_i)
                        !grant_i[o][o])
                        else $error("output %0d granted its own input", o);

                // registered valid follows a grant by one cycle
                a_out_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
                        out_flit_i[o].valid |-> $past(|grant_i[o]))
                        else $error("output %0d valid without a grant", o);

                for (genvar i = 0; i < noc_pkg::NUM_PORTS; i++) begin : g_in
                        a_desire: assert property (@(posedge clk) disable iff (!arst_n_i)
                                grant_i[o][i] |-> (in_flit_i[i].valid &&
                                                   in_flit_i[i].nexthop == noc_pkg::port_e'(o)))
                                else $error("output %0d granted input %0d without a request", o, i);
                end
        end

endmodule

bind router_switch router_switch_chk chk0 (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .in_flit_i  (in_flit_i),
        .grant_i    (grant),
        .out_flit_i (out_flit_o)
);

// ==== bench/router_switch_tb.sv ====
`timescale 1ns/100ps

module router_switch_tb;

        localparam int CLK_PERIOD          = 10;
        localparam int RESET_CYCLES        = 10;
        localparam int RESET_TEST_CYCLES   = 7;
        localparam int SINGLE_TEST_CYCLES  = 21;
        localparam int CONTEND_ROUNDS      = 12;
        localparam int CONTEND_TEST_CYCLES = 2 * (CONTEND_ROUNDS + 1);
        localparam int UTURN_TEST_CYCLES   = 4;
        localparam int RANDOM_ROUNDS       = 300;
        localparam int RANDOM_TEST_CYCLES  = RANDOM_ROUNDS + 1;
        localparam int MARGIN_CYCLES       = 50;
        localparam int WATCHDOG_NS = CLK_PERIOD * (RESET_CYCLES + 1 + RESET_TEST_CYCLES +
                                     SINGLE_TEST_CYCLES + CONTEND_TEST_CYCLES +
                                     UTURN_TEST_CYCLES + RANDOM_TEST_CYCLES + MARGIN_CYCLES);

        logic                  clk = 1'b0;
        logic                  arst_n_i;
        noc_pkg::flit_array_t  in_flit;
        noc_pkg::port_mask_t   in_grant;
        noc_pkg::flit_array_t  out_flit;

        logic [31:0]           lfsr_state;
        int                    ptr [noc_pkg::NUM_PORTS];   // model pointer per output
        noc_pkg::grant_array_t exp_grant;
        noc_pkg::flit_array_t  exp_out;

        always #(CLK_PERIOD / 2) clk = ~clk;

        router_switch dut0 (
                .clk        (clk),
                .arst_n_i   (arst_n_i),
                .in_flit_i  (in_flit),
                .in_grant_o (in_grant),
                .out_flit_o (out_flit)
        );

        function automatic logic [31:0] lfsr_step(input logic [31:0] s);
                logic [31:0] n;
                n = s >> 1;
                if (s[0]) begin
                        n = n ^ 32'h8020_0003;
                end
                return n;
        endfunction

        function automatic logic [31:0] rand_bits(input int n);
                logic [31:0] v;
                v = '0;
                for (int k = 0; k < n; k++) begin
                        lfsr_state = lfsr_step(lfsr_state);     // one step per bit
                        v = {v[30:0], lfsr_state[0]};
                end
                return v;
        endfunction

        function automatic logic [noc_pkg::DATA_W-1:0] rand_payload();
                logic [31:0] v;
                v = rand_bits(noc_pkg::DATA_W);
                return v[noc_pkg::DATA_W-1:0];
        endfunction

        function automatic noc_pkg::flit_t make_flit(input int dest,
                                                     input logic [noc_pkg::DATA_W-1:0] data);
                noc_pkg::flit_t f;
                f.valid   = 1'b1;
                f.nexthop = noc_pkg::port_e'(dest);
                f.payload = data;
                return f;
        endfunction

        function automatic noc_pkg::port_mask_t one_hot(input int i);
                return noc_pkg::port_mask_t'(1) << i;
        endfunction

        function automatic int first_set(input noc_pkg::port_mask_t m);
                int idx;
                idx = -1;
                for (int i = noc_pkg::NUM_PORTS - 1; i >= 0; i--) begin
                        if (m[i]) begin
                                idx = i;
                        end
                end
                return idx;
        endfunction

        // port after i that is not the output itself
        function automatic int next_ptr(input int i, input int o);
                int n;
                n = (i + 1) % noc_pkg::NUM_PORTS;
                if (n == o) begin
                        n = (n + 1) % noc_pkg::NUM_PORTS;
                end
                return n;
        endfunction

        task automatic fail_run(input string why);
                $display("%s", why);
                $display("TESTS FAILED");
                $fatal(1);
        endtask

        task automatic compare_grant(input string name, input noc_pkg::port_mask_t got,
                                     input noc_pkg::port_mask_t exp);
                if (got !== exp) begin
                        fail_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
                end
        endtask

        // payload and next-hop only matter while valid
        task automatic compare_flit(input string name, input noc_pkg::flit_t got,
                                    input noc_pkg::flit_t exp);
                if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
                        fail_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
                end
        endtask

        task automatic model_reset();
                for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
                        ptr[o]     = (o == 0) ? 1 : 0;
                        exp_out[o] = '0;
                end
        endtask

        task automatic model_arbitrate();
                int   idx;
                logic found;
                exp_grant = '0;
                for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
                        found = 1'b0;
                        for (int n = 0; n < noc_pkg::NUM_PORTS; n++) begin
                                idx = (ptr[o] + n) % noc_pkg::NUM_PORTS;
                                if (!found && idx != o && in_flit[idx].valid &&
                                    int'(in_flit[idx].nexthop) == o) begin
                                        exp_grant[o][idx] = 1'b1;
                                        found             = 1'b1;
                                end
                        end
                end
        endtask

        task automatic model_advance();
                for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
                        exp_out[o] = '0;
                        for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
                                if (exp_grant[o][i]) begin
                                        exp_out[o] = in_flit[i];
                                        ptr[o]     = next_ptr(i, o);
                                end
                        end
                end
        endtask

        // drive one cycle, check last cycle's outputs and this cycle's grants
        task automatic run_cycle(input noc_pkg::flit_array_t stim);
                noc_pkg::port_mask_t any_grant;
                @(negedge clk);
                in_flit = stim;
                #1;
                for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
                        compare_flit($sformatf("out_flit_o[%0d]", o), out_flit[o], exp_out[o]);
                end
                model_arbitrate();
                any_grant = '0;
                for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
                        any_grant = any_grant | exp_grant[o];
                end
                compare_grant("in_grant_o", in_grant, any_grant);
                model_advance();
        endtask

        task automatic test_reset();
                noc_pkg::flit_array_t stim;
                int                   src;
                run_cycle('0);                          // outputs idle out of reset
                for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
                        src     = (o + 1) % noc_pkg::NUM_PORTS;
                        stim    = '0;
                        stim[src] = make_flit(o, rand_payload());
                        run_cycle(stim);
                        compare_grant("in_grant_o", in_grant, one_hot(src));
                end
                run_cycle('0);
        endtask

        task automatic test_single();
                noc_pkg::flit_array_t stim;
                for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
                        for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
                                if (i != o) begin
                                        stim    = '0;
                                        stim[i] = make_flit(o, rand_payload());
                                        run_cycle(stim);
                                        compare_grant("in_grant_o", in_grant, one_hot(i));
                                end
                        end
                end
                run_cycle('0);                          // last flit shows up here
        endtask

        task automatic test_contention(input int o);
                noc_pkg::flit_array_t stim;
                int                   wins [noc_pkg::NUM_PORTS];
                int                   prev;
                int                   cur;
                stim = '0;
                for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
                        wins[i] = 0;
                        if (i != o) begin
                                stim[i] = make_flit(o, rand_payload());
                        end
                end
                prev = -1;
                for (int c = 0; c < CONTEND_ROUNDS; c++) begin
                        run_cycle(stim);
                        cur = first_set(in_grant);
                        if (cur < 0) begin
                                fail_run($sformatf("no input granted on contended output %0d", o));
                        end
                        if (prev >= 0 && cur != next_ptr(prev, o)) begin
                                fail_run($sformatf(
                                        "output %0d granted %0d after %0d, out of port order",
                                        o, cur, prev));
                        end
                        wins[cur]++;
                        prev = cur;
                        stim[cur].payload = rand_payload();     // winner sends its next flit
                end
                for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
                        if (i != o && wins[i] != CONTEND_ROUNDS / 4) begin
                                fail_run($sformatf(
                                        "input %0d won output %0d %0d times out of %0d cycles",
                                        i, o, wins[i], CONTEND_ROUNDS));
                        end
                end
                run_cycle('0);
        endtask

        task automatic test_uturn();
                noc_pkg::flit_array_t stim;
                for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
                        stim[i] = make_flit(i, rand_payload());
                end
                repeat (UTURN_TEST_CYCLES - 1) begin
                        run_cycle(stim);
                        compare_grant("in_grant_o", in_grant, '0);
                end
                run_cycle('0);                          // nothing may come out
        endtask

        task automatic test_random();
                noc_pkg::flit_array_t stim;
                int                   dest;
                stim = '0;
                for (int c = 0; c < RANDOM_ROUNDS; c++) begin
                        for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
                                if (!stim[i].valid) begin
                                        stim[i] = '0;
                                        if (rand_bits(1) != 0) begin
                                                dest    = (i + 1 + int'(rand_bits(2))) %
                                                          noc_pkg::NUM_PORTS;
                                                stim[i] = make_flit(dest, rand_payload());
                                        end
                                end
                        end
                        run_cycle(stim);
                        for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
                                if (in_grant[i]) begin
                                        stim[i].valid = 1'b0;   // accepted flits leave and losers stay
                                end
                        end
                end
                run_cycle('0);
        endtask

        initial begin
                #(WATCHDOG_NS);
                fail_run($sformatf("simulation still running after %0d ns, stopped by watchdog",
                                   WATCHDOG_NS));
        end

        initial begin
                arst_n_i   = 1'b0;
                in_flit    = '0;
                lfsr_state = 32'h32ea;
                model_reset();
                repeat (RESET_CYCLES) @(posedge clk);
                @(negedge clk);
                arst_n_i = 1'b1;
                test_reset();
                test_single();
                test_contention(int'(noc_pkg::PORT_S));
                test_contention(int'(noc_pkg::PORT_L));
                test_uturn();
                test_random();
                $display("TESTS PASSED");
                $finish;
        end

endmodule

// ==== build.f ====
design/noc_pkg.sv
design/rr_comparator.sv
design/rr_order_register.sv
design/rr_priority_encoder.sv
design/rr_processor.sv
design/switch_traversal.sv
design/router_switch.sv
bench/router_switch_chk.sv
bench/router_switch_tb.sv

// ==== design/noc_pkg.sv ====
package noc_pkg;

        // router geometry
        localparam int NUM_PORTS  = 5;
        localparam int PORT_IDX_W = 3;          // width of a port index / next-hop field
        localparam int DATA_W     = 16;         // flit payload width

        // port numbering is also the bit order of every mask
        typedef enum logic [PORT_IDX_W-1:0] {
                PORT_N = 3'd0,
                PORT_S = 3'd1,
                PORT_W = 3'd2,
                PORT_E = 3'd3,
                PORT_L = 3'd4
        } port_e;

        // bit i of a mask belongs to port_e'(i)
        typedef logic [NUM_PORTS-1:0] port_mask_t;

        // a single flit as seen on any router port
        typedef struct packed {
                logic                valid;
                port_e               nexthop;
                logic [DATA_W-1:0]   payload;
        } flit_t;

        // one flit per port indexed by port number
        typedef flit_t [NUM_PORTS-1:0] flit_array_t;

        // per-output grant masks indexed by output port
        typedef port_mask_t [NUM_PORTS-1:0] grant_array_t;

endpackage

// ==== design/router_switch.sv ====
`timescale 1ns/100ps

module router_switch (
        input  logic                 clk,
        input  logic                 arst_n_i,
        input  noc_pkg::flit_array_t in_flit_i,
        output noc_pkg::port_mask_t  in_grant_o,
        output noc_pkg::flit_array_t out_flit_o
);

        noc_pkg::grant_array_t grant;           // grant[output][input]
        noc_pkg::port_mask_t   sel_valid;       // one strobe per output

        // one round-robin arbiter per output port
        for (genvar p = 0; p < noc_pkg::NUM_PORTS; p++) begin : g_proc
                rr_processor #(
                        .OUT_PORT (noc_pkg::port_e'(p))
                ) proc0 (
                        .clk         (clk),
                        .arst_n_i    (arst_n_i),
                        .in_flit_i   (in_flit_i),
                        .grant_o     (grant[p]),
                        .sel_valid_o (sel_valid[p])
                );
        end

        // an input wins at most one output since it has a single next-hop
        always_comb begin
                in_grant_o = '0;
                for (int p = 0; p < noc_pkg::NUM_PORTS; p++) begin
                        in_grant_o = in_grant_o | grant[p];
                end
        end

        switch_traversal xbar0 (
                .clk         (clk),
                .arst_n_i    (arst_n_i),
                .in_flit_i   (in_flit_i),
                .grant_i     (grant),
                .sel_valid_i (sel_valid),
                .out_flit_o  (out_flit_o)
        );

endmodule

// ==== design/rr_comparator.sv ====
`timescale 1ns/100ps

module rr_comparator #(
        parameter noc_pkg::port_e OUT_PORT = noc_pkg::PORT_N
) (
        input  noc_pkg::flit_array_t in_flit_i,
        output noc_pkg::port_mask_t  desire_o
);

        // one requester per input port, the own port never requests
        for (genvar i = 0; i < noc_pkg::NUM_PORTS; i++) begin : g_desire
                if (i == int'(OUT_PORT)) begin : g_uturn
                        assign desire_o[i] = 1'b0;      // no u-turn
                end else begin : g_cmp
                        assign desire_o[i] = in_flit_i[i].valid &&
                                             (in_flit_i[i].nexthop == OUT_PORT);
                end
        end

endmodule

// ==== design/rr_order_register.sv ====
`timescale 1ns/100ps

module rr_order_register #(
        parameter noc_pkg::port_e OUT_PORT = noc_pkg::PORT_N
) (
        input  logic                clk,
        input  logic                arst_n_i,
        input  noc_pkg::port_mask_t grant_i,
        output noc_pkg::port_mask_t order_o
);

        noc_pkg::port_mask_t order_q;
        noc_pkg::port_mask_t next_order;

        // circular shift by one position towards the higher port index
        function automatic noc_pkg::port_mask_t rotl1(input noc_pkg::port_mask_t m);
                return {m[noc_pkg::NUM_PORTS-2:0], m[noc_pkg::NUM_PORTS-1]};
        endfunction

        // pointer moves to the port after the winner and skips the output port
        always_comb begin
                next_order = rotl1(grant_i);
                if (next_order[OUT_PORT]) begin
                        next_order = rotl1(next_order);
                end
        end

        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        // lowest port that is not the output itself
                        order_q <= (OUT_PORT == noc_pkg::PORT_N) ? noc_pkg::port_mask_t'(2) :
                                                                   noc_pkg::port_mask_t'(1);
                end else if (|grant_i) begin
                        order_q <= next_order;          // hold when nobody won
                end
        end

        assign order_o = order_q;

endmodule

// ==== design/rr_priority_encoder.sv ====
`timescale 1ns/100ps

module rr_priority_encoder (
        input  noc_pkg::port_mask_t desire_i,
        input  noc_pkg::port_mask_t order_i,
        output noc_pkg::port_mask_t grant_o,
        output logic                sel_valid_o
);

        // walk all five positions once, starting at the one-hot pointer
        always_comb begin
                int   idx;
                logic found;

                grant_o = '0;
                found   = 1'b0;
                idx     = 0;
                for (int start = 0; start < noc_pkg::NUM_PORTS; start++) begin
                        if (order_i[start]) begin
                                for (int n = 0; n < noc_pkg::NUM_PORTS; n++) begin
                                        idx = (start + n) % noc_pkg::NUM_PORTS;    // wrap
                                        if (!found && desire_i[idx]) begin
                                                grant_o[idx] = 1'b1;
                                                found        = 1'b1;
                                        end
                                end
                        end
                end
        end

        assign sel_valid_o = |grant_o;                  // crossbar loads this output

endmodule

// ==== design/rr_processor.sv ====
`timescale 1ns/100ps

module rr_processor #(
        parameter noc_pkg::port_e OUT_PORT = noc_pkg::PORT_N
) (
        input  logic                 clk,
        input  logic                 arst_n_i,
        input  noc_pkg::flit_array_t in_flit_i,
        output noc_pkg::port_mask_t  grant_o,
        output logic                 sel_valid_o
);

        noc_pkg::port_mask_t desire;
        noc_pkg::port_mask_t order;

        rr_comparator #(
                .OUT_PORT (OUT_PORT)
        ) cmp0 (
                .in_flit_i (in_flit_i),
                .desire_o  (desire)
        );

        // advanced by our own grant, no external order strobe
        rr_order_register #(
                .OUT_PORT (OUT_PORT)
        ) order_reg0 (
                .clk      (clk),
                .arst_n_i (arst_n_i),
                .grant_i  (grant_o),
                .order_o  (order)
        );

        rr_priority_encoder prio_enc0 (
                .desire_i    (desire),
                .order_i     (order),
                .grant_o     (grant_o),
                .sel_valid_o (sel_valid_o)
        );

endmodule

// ==== design/switch_traversal.sv ====
`timescale 1ns/100ps

module switch_traversal (
        input  logic                  clk,
        input  logic                  arst_n_i,
        input  noc_pkg::flit_array_t  in_flit_i,
        input  noc_pkg::grant_array_t grant_i,
        input  noc_pkg::port_mask_t   sel_valid_i,
        output noc_pkg::flit_array_t  out_flit_o
);

        for (genvar o = 0; o < noc_pkg::NUM_PORTS; o++) begin : g_out
                noc_pkg::flit_t              mux_flit;
                logic                        valid_q;
                noc_pkg::port_e              nexthop_q;
                logic [noc_pkg::DATA_W-1:0]  payload_q;

                // one-hot grant selects the input flit
                always_comb begin
                        mux_flit = '0;
                        for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
                                if (grant_i[o][i]) begin
                                        mux_flit = in_flit_i[i];
                                end
                        end
                end

                always_ff @(posedge clk or negedge arst_n_i) begin
                        if (!arst_n_i) begin
                                valid_q <= 1'b0;
                        end else begin
                                valid_q <= sel_valid_i[o] & mux_flit.valid;  // drops after idle
                        end
                end

                always_ff @(posedge clk) begin
                        if (sel_valid_i[o]) begin
                                nexthop_q <= mux_flit.nexthop;
                                payload_q <= mux_flit.payload;
                        end
                end

                assign out_flit_o[o] = '{valid: valid_q, nexthop: nexthop_q, payload: payload_q};
        end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
        --top-module router_switch_tb -f build.f

out=$(./obj_dir/Vrouter_switch_tb 2>&1) || true
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q '^TESTS PASSED$'
